//--- build.f
logic/fetch_pkg.sv
logic/fetch_buf_if.sv
logic/fetch_ctl.sv
logic/fetch_mem.sv
logic/fetch_buf_slot.sv
logic/fetch_align.sv
logic/fetch_top.sv
verif/fetch_clk_gen.sv
verif/fetch_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing
LINT     = --lint-only -Wall --timing
TOP      = fetch_tb
RTL_TOP  = fetch_top
FILELIST = build.f
OBJDIR   = obj_dir
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run lint clean

all: run

$(OBJDIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)

run: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "sim passed" $(LOG)

lint:
	$(TOOL) $(LINT) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- verif/fetch_patterns.txt
// Word 0 is the image size, then image words from address 0, then the record count
// Records are cycle, command (0 end, 1 flush, 2 halt, 3 take mode) and argument, all hex
00000018
00000013 00100093 00200113 00300193
00400213 00500293 00600313 00700393
00800413 00900493 00a00513 00b00593
00c00613 00d00693 00e00713 00f00793
01000813 01100893 01200913 01300993
01400a13 01500a93 01600b13 01700b93
// Record count
0000000d
// Start at 0, single takes
0000 1 0000
0000 3 0001
// Back-pressure, nothing taken
003c 3 0000
// Pairs
005a 3 0002
// Random takes
0096 3 0003
// Redirect
00dc 1 0042
// Halt, then resume just below the wrap
012c 2 0000
0154 1 00fa
01a4 3 0002
// Redirect back into the image
01e0 1 0013
01e0 3 0001
0208 3 0003
// End at cycle 560, at least 100 words
0230 0 0064

//--- verif/fetch_tb.sv
// Testbench of the fetch front end that replays the pattern file and checks the taken word stream
`timescale 1ns/10ps

module fetch_tb
   import fetch_pkg::*;
();

   localparam int PAT_WORDS    = 512;    // Pattern buffer depth
   localparam int WATCH_MARGIN = 2000;   // Cycles allowed past the last command
   localparam int CMD_END      = 0;      // Drain with a minimum word count
   localparam int CMD_FLUSH    = 1;      // Redirect to argument
   localparam int CMD_HALT     = 2;      // Flush into idle
   localparam int CMD_TAKE     = 3;      // Take mode 0 hold, 1 single, 2 pair, 3 random

   logic  clk;
   logic  rst_n;
   logic  flush;
   logic  halt;
   addr_t flush_addr;
   logic  take;
   logic  take_two;
   logic  load_en;
   addr_t load_addr;
   insn_t load_data;
   logic  insn0_valid;
   logic  insn1_valid;
   addr_t insn0_addr;
   addr_t insn1_addr;
   insn_t insn0_data;
   insn_t insn1_data;
   logic  fetch_stall;

   logic [31:0] pat [PAT_WORDS];     // Raw pattern file
   insn_t       image [MEM_WORDS];   // Expected memory contents
   int          img_words;
   int          rec_base;            // First record word
   int          rec_cnt;
   int          rec_idx;             // Next record to apply
   int          cyc;                 // Program cycle
   int          end_cycle;
   int          min_words;
   int          take_mode;
   int          err_cnt;
   int          word_cnt;
   int          stall_cnt;
   int          watch_cycles;
   logic        watch_armed = 1'b0;
   logic        file_ok;
   logic [31:0] lfsr;
   addr_t       exp_addr;            // Next address the stream owes
   logic        halted;              // No output allowed

   fetch_clk_gen u_clk (.clk, .rst_n);

   fetch_top dut0 (.clk, .rst_n, .flush, .halt, .flush_addr, .take, .take_two,
                   .load_en, .load_addr, .load_data, .insn0_valid, .insn1_valid,
                   .insn0_addr, .insn1_addr, .insn0_data, .insn1_data, .fetch_stall);

   // *******************************************************************
   // Stimulus helpers
   // *******************************************************************
   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic draw_bit(output logic b);
      lfsr = lfsr_next(lfsr);
      b = lfsr[0];
   endtask

   // Words beyond the file image
   function automatic insn_t fill_word(input addr_t a);
      return {a ^ 16'hc3a5, a};
   endfunction

   task automatic read_patterns();
      int last;
      file_ok = 1'b0;
      $readmemh("verif/fetch_patterns.txt", pat);
      if ($isunknown(pat[0])) return;
      img_words = int'(pat[0]);
      if (img_words > MEM_WORDS) return;
      rec_cnt  = int'(pat[img_words + 1]);
      rec_base = img_words + 2;
      last     = rec_base + 3 * (rec_cnt - 1);     // End record
      if (rec_cnt < 1 || last + 2 >= PAT_WORDS) return;
      if (pat[last + 1] !== 32'(CMD_END)) return;
      end_cycle = int'(pat[last]);
      min_words = int'(pat[last + 2]);
      for (int k = 0; k < MEM_WORDS; k++) begin
         if (k < img_words) image[k] = pat[k + 1];
         else image[k] = fill_word(addr_t'(k));
      end
      file_ok = 1'b1;
   endtask

   // Whole array through the load port while fetch is halted
   task automatic load_memory();
      for (int a = 0; a < MEM_WORDS; a++) begin
         @(posedge clk);
         load_en   <= 1'b1;
         load_addr <= addr_t'(a);
         load_data <= image[a];
      end
      @(posedge clk);
      load_en <= 1'b0;
   endtask

   task automatic apply_commands();
      int cmd;
      int arg;
      flush <= 1'b0;            // Flush is a one cycle pulse
      halt  <= 1'b0;
      while (rec_idx < rec_cnt && int'(pat[rec_base + 3 * rec_idx]) == cyc) begin
         cmd = int'(pat[rec_base + 3 * rec_idx + 1]);
         arg = int'(pat[rec_base + 3 * rec_idx + 2]);
         if (cmd == CMD_FLUSH || cmd == CMD_HALT) begin
            flush      <= 1'b1;
            halt       <= (cmd == CMD_HALT);
            flush_addr <= addr_t'(arg);
            exp_addr   = addr_t'(arg);     // Older words must not show up
            halted     = (cmd == CMD_HALT);
         end else if (cmd == CMD_TAKE) begin
            take_mode = arg;
         end else begin
            take_mode = 1;                 // Drain
         end
         rec_idx++;
      end
   endtask

   task automatic drive_take();
      logic b_one;
      logic b_two;
      case (take_mode)
         0: begin
            take     <= 1'b0;
            take_two <= 1'b0;
         end
         1: begin
            take     <= 1'b1;
            take_two <= 1'b0;
         end
         2: begin
            take     <= 1'b1;              // Single word when only one is there
            take_two <= 1'b1;
         end
         default: begin
            draw_bit(b_one);
            draw_bit(b_two);
            take     <= b_one;
            take_two <= b_two;
         end
      endcase
   endtask

   // *******************************************************************
   // Checks
   // *******************************************************************
   task automatic check_word(input string which, input addr_t a, input insn_t d);
      if (a != exp_addr) begin
         $display("CHECK FAILED at %0t: %s address %h, expected %h", $time, which, a, exp_addr);
         err_cnt++;
         exp_addr = a;                     // Follow the DUT address from here
      end
      if (d != image[exp_addr[MEM_AW-1:0]]) begin
         $display("CHECK FAILED at %0t: %s data %h at %h, expected %h", $time, which, d,
                  exp_addr, image[exp_addr[MEM_AW-1:0]]);
         err_cnt++;
      end
      word_cnt++;
      exp_addr = (exp_addr + addr_t'(1)) & ADDR_MASK;   // Stream wraps with the array
   endtask

   task automatic check_outputs();
      if (fetch_stall) stall_cnt++;
      if (halted) begin
         if (insn0_valid || insn1_valid) begin
            $display("CHECK FAILED at %0t: output valid at %h while halted", $time, insn0_addr);
            err_cnt++;
         end
         // Idle has no miss wait and no blocked request
         if (!flush && fetch_stall) begin
            $display("CHECK FAILED at %0t: fetch_stall high while halted", $time);
            err_cnt++;
         end
      end else begin
         if (insn1_valid && !insn0_valid) begin
            $display("CHECK FAILED at %0t: insn1 valid without insn0", $time);
            err_cnt++;
         end
         if (insn1_valid && insn1_addr != ((insn0_addr + addr_t'(1)) & ADDR_MASK)) begin
            $display("CHECK FAILED at %0t: pair %h %h not consecutive", $time, insn0_addr,
                     insn1_addr);
            err_cnt++;
         end
         if (take_two && insn1_valid) begin          // Pair consumed
            check_word("insn0", insn0_addr, insn0_data);
            check_word("insn1", insn1_addr, insn1_data);
         end else if (take && insn0_valid) begin
            check_word("insn0", insn0_addr, insn0_data);
         end
      end
   endtask

   // *******************************************************************
   // Main sequence
   // *******************************************************************
   initial begin : main
      flush      = 1'b1;       // Halted through reset and preload
      halt       = 1'b1;
      flush_addr = RESET_ADDR;
      take       = 1'b0;
      take_two   = 1'b0;
      load_en    = 1'b0;
      load_addr  = '0;
      load_data  = '0;
      err_cnt    = 0;
      word_cnt   = 0;
      stall_cnt  = 0;
      take_mode  = 0;
      rec_idx    = 0;
      cyc        = 0;
      lfsr       = 32'h45f9;
      halted     = 1'b1;
      exp_addr   = RESET_ADDR;
      read_patterns();
      if (!file_ok) begin
         $display("Pattern file verif/fetch_patterns.txt is missing or malformed");
         $display("sim failed");
         $finish;
      end else begin
         watch_cycles = MEM_WORDS + 2 + end_cycle + WATCH_MARGIN;
         watch_armed  = 1'b1;
         load_memory();
         // Sample between edges where inputs and outputs are settled
         while (cyc <= end_cycle || word_cnt < min_words) begin
            @(posedge clk);
            apply_commands();
            drive_take();
            @(negedge clk);
            check_outputs();
            cyc++;
         end
         if (stall_cnt == 0) begin
            $display("The fetch_stall output was never seen high during the run");
            err_cnt++;
         end
         $display("errors: %0d, words checked: %0d, stall cycles: %0d", err_cnt, word_cnt,
                  stall_cnt);
         if (err_cnt == 0) $display("sim passed");
         else $display("sim failed");
         $finish;
      end
   end

   initial begin : watchdog
      wait (watch_armed);
      repeat (watch_cycles) @(posedge clk);
      $display("Watchdog timeout after %0d cycles, the word stream stopped", watch_cycles);
      $display("sim failed");
      $finish;
   end

endmodule

//--- verif/fetch_clk_gen.sv
// Testbench clock and reset source, 8 ns clock with reset held low for the first 5 cycles
`timescale 1ns/10ps

module fetch_clk_gen (
   output logic clk,     // 125 MHz core clock
   output logic rst_n    // Sync reset, active low
);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;    // Half period
   end

   initial begin
      rst_n = 1'b0;
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;            // Released on the 5th rising edge
   end

endmodule

//--- logic/fetch_top.sv
// Fetch front end top level, joins controller, memory model, buffer slots and aligner
`timescale 1ns/10ps

module fetch_top
   import fetch_pkg::*;
(
   input  logic  clk,           // Core clock
   input  logic  rst_n,         // Sync reset, active low
   input  logic  flush,         // Redirect
   input  logic  halt,          // With flush, go idle
   input  addr_t flush_addr,
   input  logic  take,          // Consumer takes one
   input  logic  take_two,      // Consumer takes two
   input  logic  load_en,       // Memory preload
   input  addr_t load_addr,
   input  insn_t load_data,
   output logic  insn0_valid,
   output logic  insn1_valid,
   output addr_t insn0_addr,
   output addr_t insn1_addr,
   output insn_t insn0_data,
   output insn_t insn1_data,
   output logic  fetch_stall    // Stall event
);

   fetch_buf_if fb ();

   addr_t fetch_addr;
   logic  fetch_req;
   logic  hit;
   logic  fill_done;
   insn_t rdata;

   // Slot outputs, two extra entries above the top slot read as empty
   logic  s_valid [FB_DEPTH+2];
   addr_t s_addr  [FB_DEPTH+2];
   insn_t s_data  [FB_DEPTH+2];

   assign fb.write_data = rdata;   // Memory word onto the buffer bus

   fetch_ctl u_ctl (.clk, .rst_n, .hit, .fill_done, .flush, .halt, .flush_addr,
                    .fetch_addr, .fetch_req, .fetch_stall, .fb(fb));

   fetch_mem u_mem (.clk, .rst_n, .fetch_addr, .fetch_req, .load_en, .load_addr,
                    .load_data, .hit, .fill_done, .rdata);

   // *******************************************************************
   // Buffer slots
   // *******************************************************************
   for (genvar k = FB_DEPTH; k < FB_DEPTH + 2; k++) begin : g_tie
      assign s_valid[k] = 1'b0;
      assign s_addr[k]  = '0;
      assign s_data[k]  = '0;
   end

   for (genvar i = 0; i < FB_DEPTH; i++) begin : g_slot
      fetch_buf_slot #(.SLOT(i)) u_slot (
         .clk, .rst_n, .fb(fb),
         .up1_valid(s_valid[i+1]), .up2_valid(s_valid[i+2]),
         .up1_addr(s_addr[i+1]),   .up2_addr(s_addr[i+2]),
         .up1_data(s_data[i+1]),   .up2_data(s_data[i+2]),
         .valid(s_valid[i]), .addr(s_addr[i]), .data(s_data[i]));
   end

   fetch_align u_align (
      .clk, .rst_n, .take, .take_two,
      .s0_valid(s_valid[0]), .s0_addr(s_addr[0]), .s0_data(s_data[0]),
      .s1_valid(s_valid[1]), .s1_addr(s_addr[1]), .s1_data(s_data[1]),
      .insn0_valid, .insn1_valid, .insn0_addr, .insn1_addr,
      .insn0_data, .insn1_data, .fb(fb));

endmodule

//--- logic/fetch_align.sv
// Aligner that shows the two oldest buffer slots and drains one or two of them per cycle
`timescale 1ns/10ps

module fetch_align
   import fetch_pkg::*;
(
   input  logic       clk,           // Core clock
   input  logic       rst_n,         // Sync reset, active low
   input  logic       take,          // Consumer takes insn0
   input  logic       take_two,      // Consumer takes insn0 and insn1
   input  logic       s0_valid,      // Oldest slot
   input  addr_t      s0_addr,
   input  insn_t      s0_data,
   input  logic       s1_valid,      // Next oldest
   input  addr_t      s1_addr,
   input  insn_t      s1_data,
   output logic       insn0_valid,
   output logic       insn1_valid,
   output addr_t      insn0_addr,
   output addr_t      insn1_addr,
   output insn_t      insn0_data,
   output insn_t      insn1_data,
   fetch_buf_if.align fb             // Consume pulses, flush
);

   logic out_ok;     // Outputs may be shown and taken
   logic pair_ok;    // Both slots hold words

   // *******************************************************************
   // Output view
   // *******************************************************************
   // Slots are being cleared this cycle
   assign out_ok  = ~fb.flush;
   assign pair_ok = s0_valid & s1_valid;

   assign insn0_valid = s0_valid & out_ok;
   assign insn1_valid = pair_ok & out_ok;    // Never insn1 without insn0
   assign insn0_addr  = s0_addr;
   assign insn0_data  = s0_data;
   assign insn1_addr  = s1_addr;
   assign insn1_data  = s1_data;

   // *******************************************************************
   // Consume
   // *******************************************************************
   assign fb.consume2 = take_two & pair_ok & out_ok;                      // Pair first
   assign fb.consume1 = ~fb.consume2 & take & s0_valid & out_ok;          // Else single word

endmodule

//--- logic/fetch_buf_slot.sv
// One fetch buffer entry, shifts toward slot 0 on consume and loads the hit word at its position
`timescale 1ns/10ps

module fetch_buf_slot
   import fetch_pkg::*;
#(
   parameter int SLOT = 0   // Index of this slot
)(
   input  logic      clk,         // Core clock
   input  logic      rst_n,       // Sync reset, active low
   fetch_buf_if.slot fb,          // Buffer bus
   input  logic      up1_valid,   // Slot SLOT+1
   input  logic      up2_valid,   // Slot SLOT+2
   input  addr_t     up1_addr,
   input  addr_t     up2_addr,
   input  insn_t     up1_data,
   input  insn_t     up2_data,
   output logic      valid,
   output addr_t     addr,
   output insn_t     data
);

   logic load_write;

   assign load_write = fb.write_en & fb.write_pos[SLOT];   // Write aimed here

   always_ff @(posedge clk) begin
      if (!rst_n) valid <= 1'b0;
      else if (fb.flush) valid <= 1'b0;
      else if (load_write) valid <= 1'b1;
      else if (fb.consume2) valid <= up2_valid;
      else if (fb.consume1) valid <= up1_valid;
   end

   // Payload follows the same choice
   always_ff @(posedge clk) begin
      if (load_write) begin
         addr <= fb.write_addr;
         data <= fb.write_data;
      end else if (fb.consume2) begin
         addr <= up2_addr;
         data <= up2_data;
      end else if (fb.consume1) begin
         addr <= up1_addr;
         data <= up1_data;
      end
   end

endmodule

//--- logic/fetch_mem.sv
// Instruction memory model with one cached line, answers fetches with a hit or a timed fill
`timescale 1ns/10ps

module fetch_mem
   import fetch_pkg::*;
(
   input  logic  clk,          // Core clock
   input  logic  rst_n,        // Sync reset, active low
   input  addr_t fetch_addr,   // F address
   input  logic  fetch_req,    // F request valid
   input  logic  load_en,      // Preload write
   input  addr_t load_addr,
   input  insn_t load_data,
   output logic  hit,          // Request is in the cached line
   output logic  fill_done,    // Fill pulse, tag valid next cycle
   output insn_t rdata         // Word at fetch_addr
);

   insn_t     mem_q [MEM_WORDS];   // Word array
   line_tag_t tag_q;               // Cached line
   line_tag_t fill_line_q;         // Line being filled
   line_tag_t req_line;
   logic      tag_valid_q;
   lat_cnt_t  cnt_q;               // Cycles left in the fill
   logic      fill_idle;
   logic      fill_last;
   logic      start_fill;

   assign req_line = fetch_addr[MEM_AW-1:LINE_AW];          // Upper bits wrap
   assign hit      = fetch_req & tag_valid_q & (req_line == tag_q);
   assign rdata    = mem_q[fetch_addr[MEM_AW-1:0]];

   // *******************************************************************
   // Miss fill timing
   // *******************************************************************
   assign fill_idle = (cnt_q == '0);
   assign fill_last = (cnt_q == lat_cnt_t'(1));
   assign fill_done = fill_last;

   // A miss while a fill runs waits for that fill to end
   assign start_fill = fetch_req & ~hit & (fill_idle | fill_last);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cnt_q       <= '0;
         tag_valid_q <= 1'b0;
      end else begin
         if (start_fill) cnt_q <= lat_cnt_t'(MISS_LATENCY);
         else if (!fill_idle) cnt_q <= cnt_q - lat_cnt_t'(1);

         if (load_en) tag_valid_q <= 1'b0;            // Image changed under the line
         else if (fill_last) tag_valid_q <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (start_fill) fill_line_q <= req_line;   // Capture the missed line
      if (fill_last) tag_q <= fill_line_q;
   end

   // Preload port
   always_ff @(posedge clk) begin
      if (load_en) mem_q[load_addr[MEM_AW-1:0]] <= load_data;
   end

endmodule

//--- logic/fetch_ctl.sv
// Fetch controller, picks the next fetch address, runs the fetch FSM and tracks buffer fill
`timescale 1ns/10ps

module fetch_ctl
   import fetch_pkg::*;
(
   input  logic     clk,           // Core clock
   input  logic     rst_n,         // Sync reset, active low
   input  logic     hit,           // Memory hit for the F request
   input  logic     fill_done,     // Line fill complete
   input  logic     flush,         // Redirect
   input  logic     halt,          // With flush, stop fetching
   input  addr_t    flush_addr,    // Redirect target
   output addr_t    fetch_addr,    // F address
   output logic     fetch_req,     // F request valid
   output logic     fetch_stall,   // Stall event
   fetch_buf_if.ctl fb             // Buffer write and consume bus
);

   fetch_state_t state;
   fetch_state_t next_state;
   addr_t        fetch_addr_bf;      // BF address
   addr_t        fetch_addr_next;    // Sequential address
   fb_pos_t      fb_write_f;         // Current write position
   fb_pos_t      fb_write_ns;
   logic         fetch_req_bf;
   logic         fetch_bf_en;
   logic         sel_last_addr_bf;
   logic         sel_next_addr_bf;
   logic         hit_f;              // Word written this cycle
   logic         miss_f;
   logic         goto_idle;
   logic         leave_idle;
   logic         consume;
   logic         fb_left;
   logic         fb_right;
   logic         fb_right2;
   logic         fb_full_ns;

   assign consume = fb.consume1 | fb.consume2;
   assign hit_f   = fetch_req & hit & ~flush;
   assign miss_f  = fetch_req & ~hit & ~flush;

   // *******************************************************************
   // BF address mux
   // *******************************************************************
   assign sel_next_addr_bf = ~flush & fetch_req & hit;      // Hit, move on
   assign sel_last_addr_bf = ~flush & ~(fetch_req & hit);   // Miss or no request, hold

   assign fetch_addr_next = (fetch_addr + addr_t'(1)) & ADDR_MASK;   // Wraps with the array

   assign fetch_addr_bf = ({$bits(addr_t){flush}}            & flush_addr)   |  // Redirect
                          ({$bits(addr_t){sel_last_addr_bf}} & fetch_addr)   |  // Hold
                          ({$bits(addr_t){sel_next_addr_bf}} & fetch_addr_next); // Sequential

   assign fetch_bf_en = flush | fetch_req;

   // *******************************************************************
   // Fetch FSM
   // *******************************************************************
   assign goto_idle  = flush & halt;    // Halt
   assign leave_idle = flush & ~halt;   // Plain redirect restarts fetch

   always_comb begin
      next_state = state;
      case (state)
         IDLE: begin
            if (leave_idle) next_state = FETCH;
         end
         FETCH: begin
            if (goto_idle) next_state = IDLE;
            else if (miss_f) next_state = WFM;
         end
         WFM: begin
            if (goto_idle) next_state = IDLE;
            else if (fill_done) next_state = FETCH;
            else if (flush) next_state = STALL;       // Old fill still busy
         end
         STALL: begin
            if (goto_idle) next_state = IDLE;
            else if (fill_done) next_state = FETCH;   // Memory free again
         end
         default: next_state = FETCH;
      endcase
   end

   // *******************************************************************
   // Buffer mass balance
   // *******************************************************************
   assign fb_left   = hit_f & ~consume;                                   // Net one in
   assign fb_right  = (fb.consume1 & ~hit_f) | (fb.consume2 & hit_f);     // Net one out
   assign fb_right2 = fb.consume2 & ~hit_f;                               // Net two out

   always_comb begin
      if (flush) fb_write_ns = fb_pos_t'(1);          // Empty
      else if (fb_right) fb_write_ns = fb_write_f >> 1;
      else if (fb_right2) fb_write_ns = fb_write_f >> 2;
      else if (fb_left) fb_write_ns = fb_write_f << 1;
      else fb_write_ns = fb_write_f;
   end

   // Slot for the hit word, after the shift of this cycle
   always_comb begin
      if (fb.consume2) fb.write_pos = fb_write_f >> 2;
      else if (fb.consume1) fb.write_pos = fb_write_f >> 1;
      else fb.write_pos = fb_write_f;
   end

   assign fb_full_ns = fb_write_ns[FB_DEPTH-1];   // Includes this cycle's consume

   // Request only when staying in FETCH with room for the word
   assign fetch_req_bf = (next_state == FETCH) & ~fb_full_ns;

   assign fetch_stall = (state == WFM) |
                        ((next_state == FETCH) & fb_full_ns);   // Blocked by full buffer

   assign fb.write_en   = hit_f;
   assign fb.write_addr = fetch_addr;
   assign fb.flush      = flush;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state      <= FETCH;
         fetch_req  <= 1'b0;
         fb_write_f <= fb_pos_t'(1);
         fetch_addr <= RESET_ADDR;
      end else begin
         state      <= next_state;
         fetch_req  <= fetch_req_bf;     // BF to F
         fb_write_f <= fb_write_ns;
         if (fetch_bf_en) fetch_addr <= fetch_addr_bf;
      end
   end

endmodule

//--- logic/fetch_buf_if.sv
// Fetch buffer bus, written by the controller and read by the buffer slots and the aligner
`timescale 1ns/10ps

interface fetch_buf_if
   import fetch_pkg::*;
();

   logic    write_en;     // Hit word lands this cycle
   fb_pos_t write_pos;    // Target slot, already moved for this cycle's consume
   addr_t   write_addr;   // Address of the hit word
   insn_t   write_data;   // Hit word from memory
   logic    consume1;     // Aligner drains slot 0
   logic    consume2;     // Aligner drains slots 0 and 1
   logic    flush;        // Clear all slots

   modport ctl (output write_en, write_pos, write_addr, flush,
                input  consume1, consume2);

   modport slot (input write_en, write_pos, write_addr, write_data,
                 input consume1, consume2, flush);

   modport align (output consume1, consume2,
                  input  flush);

endinterface

//--- logic/fetch_pkg.sv
// Widths, types and constants of the fetch front end, imported by every RTL block of it
package fetch_pkg;

   // *******************************************************************
   // Sizes
   // *******************************************************************
   localparam int FB_DEPTH     = 4;     // Fetch buffer slots
   localparam int LINE_WORDS   = 4;     // Words per memory line
   localparam int MEM_WORDS    = 256;   // Instruction array depth
   localparam int MISS_LATENCY = 4;     // Cycles from miss to fill complete

   localparam int MEM_AW  = $clog2(MEM_WORDS);          // Array index bits
   localparam int LINE_AW = $clog2(LINE_WORDS);         // Word in line bits
   localparam int TAG_W   = MEM_AW - LINE_AW;           // Line number bits
   localparam int LAT_W   = $clog2(MISS_LATENCY + 1);   // Fill counter bits

   // *******************************************************************
   // Types
   // *******************************************************************
   typedef logic [15:0]         addr_t;      // Word address
   typedef logic [31:0]         insn_t;      // Instruction word
   typedef logic [FB_DEPTH-1:0] fb_pos_t;    // One-hot write position, bit 0 empty
   typedef logic [TAG_W-1:0]    line_tag_t;  // Memory line number
   typedef logic [LAT_W-1:0]    lat_cnt_t;   // Miss fill down-counter

   // Fetch FSM encoding
   typedef enum logic [1:0] {
      IDLE  = 2'b00,   // No requests
      FETCH = 2'b01,   // Sequential fetch
      STALL = 2'b10,   // Redirected while a fill is still running
      WFM   = 2'b11    // Wait for miss fill
   } fetch_state_t;

   // *******************************************************************
   // Addresses
   // *******************************************************************
   localparam addr_t RESET_ADDR = 16'h0000;                 // Fetch start after reset
   localparam addr_t ADDR_MASK  = addr_t'(MEM_WORDS - 1);   // Wrap to array size

endpackage
